// File: src.f
+incdir+include
verilog/rrf_pkg.sv
verilog/rrf_write_merge.sv
verilog/rrf_cell.sv
verilog/rrf_tile.sv
verilog/rrf_read_stage.sv
verilog/rrf_top.sv
sim/rrf_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the register file testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module rrf_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vrrf_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed!" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: sim/rrf_tb.sv
/*
  Directed testbench for the retirement register file.
  Holds clock and reset, write and read driver tasks, a register model,
  the data compare task and six tests.
*/
`timescale 1ns/1ns
`include "rrf_defs.svh"

module rrf_tb;
  import rrf_pkg::*;

  localparam int NUM_REGS   = `RRF_TILES * `RRF_TILE_ENTRIES;
  localparam int MAX_CYCLES = 1000;

  logic       clk;
  logic       rst;
  logic       read_clk_en;
  rrf_addr_t  rd_addr [4];
  logic [3:0] rd_oe;
  rrf_data_t  rd_data [4];
  rrf_addr_t  wr_addr [9];
  rrf_data_t  wr_data [9];
  logic [8:0] wr_wen;

  rrf_data_t  model [NUM_REGS];  // Expected register contents.
  rrf_addr_t  held_addr [4];     // Addresses taken at the last enabled read edge.
  logic [3:0] held_oe;
  integer     seed;
  int         error_count;
  int         run_tests;
  int         failed_tests;

  rrf_top DUT (
    .clk (clk), .rst (rst), .read_clk_en (read_clk_en),
    .read0_addr (rd_addr[0]), .read0_oe (rd_oe[0]), .read0_data (rd_data[0]),
    .read1_addr (rd_addr[1]), .read1_oe (rd_oe[1]), .read1_data (rd_data[1]),
    .read2_addr (rd_addr[2]), .read2_oe (rd_oe[2]), .read2_data (rd_data[2]),
    .read3_addr (rd_addr[3]), .read3_oe (rd_oe[3]), .read3_data (rd_data[3]),
    .write0_addr (wr_addr[0]), .write0_data (wr_data[0]), .write0_wen (wr_wen[0]),
    .write1_addr (wr_addr[1]), .write1_data (wr_data[1]), .write1_wen (wr_wen[1]),
    .write2_addr (wr_addr[2]), .write2_data (wr_data[2]), .write2_wen (wr_wen[2]),
    .write3_addr (wr_addr[3]), .write3_data (wr_data[3]), .write3_wen (wr_wen[3]),
    .write4_addr (wr_addr[4]), .write4_data (wr_data[4]), .write4_wen (wr_wen[4]),
    .write5_addr (wr_addr[5]), .write5_data (wr_data[5]), .write5_wen (wr_wen[5]),
    .write6_addr (wr_addr[6]), .write6_data (wr_data[6]), .write6_wen (wr_wen[6]),
    .write7_addr (wr_addr[7]), .write7_data (wr_data[7]), .write7_wen (wr_wen[7]),
    .write8_addr (wr_addr[8]), .write8_data (wr_data[8]), .write8_wen (wr_wen[8])
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period.
  end

  initial
  begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("Timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failures found");
    $finish;
  end

  // Inputs change 2 ns after the rising edge.
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  function automatic rrf_data_t rand_data();
    return {$random(seed), $random(seed)};
  endfunction

  // Returns the lane of write port p for the given enables, or -1 when it gets none.
  function automatic int lane_of(input int p, input logic [8:0] wen);
    int k;
    k = p % 3;
    if (p < 3)
      return k;
    if (p < 6)
      return wen[k] ? k + 3 : k;
    return wen[k] ? k + 3 : -1;
  endfunction

  // Lanes land from the highest down so that the lowest lane is the last to land.
  function automatic void commit_model();
    for (int l = 5; l >= 0; l--)
    begin
      for (int p = 0; p < 9; p++)
      begin
        if (wr_wen[p] && lane_of(p, wr_wen) == l)
          model[wr_addr[p]] = wr_data[p];
      end
    end
  endfunction

  task automatic stage_write(input int p, input int reg_num, input rrf_data_t data);
    wr_addr[p] = rrf_addr_t'(reg_num);
    wr_data[p] = data;
    wr_wen[p]  = 1'b1;
  endtask

  task automatic write_cycle();
    commit_model();
    tick();
    wr_wen = '0;
  endtask

  task automatic check_data(input rrf_data_t got, input rrf_data_t exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t ns: %s read %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_ports(input string what);
    rrf_data_t exp;
    for (int p = 0; p < 4; p++)
    begin
      exp = held_oe[p] ? model[held_addr[p]] : '0;
      check_data(rd_data[p], exp, $sformatf("%s port %0d reg %0d", what, p, held_addr[p]));
    end
  endtask

  task automatic read_capture(input int a0, input int a1, input int a2, input int a3,
                              input logic [3:0] oe, input string what);
    rd_addr[0]  = rrf_addr_t'(a0);
    rd_addr[1]  = rrf_addr_t'(a1);
    rd_addr[2]  = rrf_addr_t'(a2);
    rd_addr[3]  = rrf_addr_t'(a3);
    rd_oe       = oe;
    read_clk_en = 1'b1;
    tick();
    held_addr = rd_addr;
    held_oe   = oe;
    check_ports(what);
  endtask

  task automatic read_all(input string what);
    for (int i = 0; i < NUM_REGS; i++)
      read_capture(i, (i + 8) % NUM_REGS, (i + 16) % NUM_REGS, (i + 24) % NUM_REGS,
                   4'hf, what);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    run_tests++;
    if (error_count == errs_before)
      $display("%s: ok", name);
    else
    begin
      failed_tests++;
      $display("%s: %0d mismatches", name, error_count - errs_before);
    end
  endtask

  task automatic test_reset_zero();
    int errs;
    errs      = error_count;
    held_addr = '{default: '0};
    held_oe   = 4'hf;
    check_ports("after reset");
    read_all("reset read");
    finish_test("reset_zero", errs);
  endtask

  task automatic test_rotate_write();
    int errs;
    int p;
    errs = error_count;
    for (int i = 0; i < NUM_REGS; i++)
    begin
      p = i % 9;
      stage_write(p, i, rand_data());
      if (p >= 6)
        stage_write(p - 6, i ^ 16, rand_data());  // Third port needs its triple's first port.
      write_cycle();
    end
    read_all("rotate read");
    finish_test("rotate_write", errs);
  endtask

  task automatic test_nine_ports();
    int        errs;
    int        regs [9];
    rrf_data_t vals [9];
    errs = error_count;
    regs = '{3, 20, 9, 27, 14, 30, 5, 18, 11};
    for (int i = 0; i < 9; i++)
      vals[i] = rand_data();
    for (int i = 0; i < 3; i++)
    begin
      stage_write(i, regs[i], vals[i]);
      stage_write(i + 6, regs[i + 3], vals[i + 3]);
    end
    write_cycle();
    for (int i = 0; i < 3; i++)
      stage_write(i + 3, regs[i + 6], vals[i + 6]);
    write_cycle();
    for (int r = 0; r < 3; r++)
    begin
      read_capture(regs[(4 * r) % 9], regs[(4 * r + 1) % 9], regs[(4 * r + 2) % 9],
                   regs[(4 * r + 3) % 9], 4'hf, "nine ports");
      for (int p = 0; p < 4; p++)
        check_data(rd_data[p], vals[(4 * r + p) % 9], $sformatf("nine ports direct %0d", p));
    end
    finish_test("nine_ports", errs);
  endtask

  task automatic test_collision();
    int        errs;
    rrf_data_t d0;
    rrf_data_t d6;
    errs = error_count;
    d0   = rand_data();
    d6   = ~d0;
    stage_write(0, 12, d0);
    stage_write(6, 12, d6);
    write_cycle();
    read_capture(12, 12, 0, 31, 4'hf, "collision");
    check_data(rd_data[0], d0, "collision port 0 data");
    finish_test("collision", errs);
  endtask

  task automatic test_read_hold();
    int        errs;
    rrf_data_t d;
    errs = error_count;
    read_capture(7, 17, 25, 2, 4'hf, "hold capture");
    read_clk_en = 1'b0;
    rd_addr     = '{1, 2, 3, 4};
    rd_oe       = 4'h0;
    tick();
    check_ports("held addresses");
    d = rand_data();
    stage_write(1, 7, d);
    write_cycle();
    check_ports("held after write");
    check_data(rd_data[0], d, "held port new write");
    read_clk_en = 1'b1;
    finish_test("read_hold", errs);
  endtask

  task automatic test_output_enable();
    int errs;
    errs = error_count;
    read_capture(4, 21, 13, 28, 4'b1010, "oe ports 0 and 2 low");
    check_data(rd_data[0], '0, "disabled port 0");
    read_capture(4, 21, 13, 28, 4'b0101, "oe ports 1 and 3 low");
    check_data(rd_data[3], '0, "disabled port 3");
    read_capture(4, 21, 13, 28, 4'hf, "oe restored");
    finish_test("output_enable", errs);
  endtask

  initial
  begin
    seed         = 32'hc2940680;
    error_count  = 0;
    run_tests    = 0;
    failed_tests = 0;
    rst          = 1'b1;
    read_clk_en  = 1'b1;
    rd_addr      = '{default: '0};
    rd_oe        = 4'hf;
    wr_addr      = '{default: '0};
    wr_data      = '{default: '0};
    wr_wen       = '0;
    model        = '{default: '0};
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    test_reset_zero();
    test_rotate_write();
    test_nine_ports();
    test_collision();
    test_read_hold();
    test_output_enable();
    $display("Tests run %0d, failed %0d, mismatches %0d", run_tests, failed_tests,
             error_count);
    if (error_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: verilog/rrf_top.sv
/*
  Floating-point retirement register file of 32 registers of 64 bits.
  Connects the write merge, the per-tile write enable gating, the two
  storage tiles and the registered read stage.
*/
`timescale 1ns/1ns
`include "rrf_defs.svh"

module rrf_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               read_clk_en,
  input  rrf_pkg::rrf_addr_t read0_addr,
  input  logic               read0_oe,
  output rrf_pkg::rrf_data_t read0_data,
  input  rrf_pkg::rrf_addr_t read1_addr,
  input  logic               read1_oe,
  output rrf_pkg::rrf_data_t read1_data,
  input  rrf_pkg::rrf_addr_t read2_addr,
  input  logic               read2_oe,
  output rrf_pkg::rrf_data_t read2_data,
  input  rrf_pkg::rrf_addr_t read3_addr,
  input  logic               read3_oe,
  output rrf_pkg::rrf_data_t read3_data,
  input  rrf_pkg::rrf_addr_t write0_addr,
  input  rrf_pkg::rrf_data_t write0_data,
  input  logic               write0_wen,
  input  rrf_pkg::rrf_addr_t write1_addr,
  input  rrf_pkg::rrf_data_t write1_data,
  input  logic               write1_wen,
  input  rrf_pkg::rrf_addr_t write2_addr,
  input  rrf_pkg::rrf_data_t write2_data,
  input  logic               write2_wen,
  input  rrf_pkg::rrf_addr_t write3_addr,
  input  rrf_pkg::rrf_data_t write3_data,
  input  logic               write3_wen,
  input  rrf_pkg::rrf_addr_t write4_addr,
  input  rrf_pkg::rrf_data_t write4_data,
  input  logic               write4_wen,
  input  rrf_pkg::rrf_addr_t write5_addr,
  input  rrf_pkg::rrf_data_t write5_data,
  input  logic               write5_wen,
  input  rrf_pkg::rrf_addr_t write6_addr,
  input  rrf_pkg::rrf_data_t write6_data,
  input  logic               write6_wen,
  input  rrf_pkg::rrf_addr_t write7_addr,
  input  rrf_pkg::rrf_data_t write7_data,
  input  logic               write7_wen,
  input  rrf_pkg::rrf_addr_t write8_addr,
  input  rrf_pkg::rrf_data_t write8_data,
  input  logic               write8_wen
);
  import rrf_pkg::*;

  localparam int IW = $bits(rrf_index_t);

  rrf_addr_t  lane_addr [6];                 // Merged write lanes.
  rrf_data_t  lane_data [6];
  logic [5:0] lane_wen;
  rrf_index_t lane_index [6];                // In-tile part of each lane address.
  rrf_index_t rd_index [4];                  // Captured in-tile read indices.
  rrf_data_t  tile_rd [`RRF_TILES][4];       // Read values per tile and port.

  rrf_write_merge u_merge (
    .*,
    .lane0_addr (lane_addr[0]), .lane0_data (lane_data[0]), .lane0_wen (lane_wen[0]),
    .lane1_addr (lane_addr[1]), .lane1_data (lane_data[1]), .lane1_wen (lane_wen[1]),
    .lane2_addr (lane_addr[2]), .lane2_data (lane_data[2]), .lane2_wen (lane_wen[2]),
    .lane3_addr (lane_addr[3]), .lane3_data (lane_data[3]), .lane3_wen (lane_wen[3]),
    .lane4_addr (lane_addr[4]), .lane4_data (lane_data[4]), .lane4_wen (lane_wen[4]),
    .lane5_addr (lane_addr[5]), .lane5_data (lane_data[5]), .lane5_wen (lane_wen[5])
  );

  for (genvar l = 0; l < 6; l++)
  begin : g_lane
    assign lane_index[l] = lane_addr[l][IW-1:0];
  end

  for (genvar t = 0; t < `RRF_TILES; t++)
  begin : g_tile
    logic [5:0] tile_wen;  // Lane enables that land in this tile.

    for (genvar l = 0; l < 6; l++)
    begin : g_wen
      assign tile_wen[l] = lane_wen[l] &&
                           (lane_addr[l][`RRF_ADDR_WIDTH-1:IW] == rrf_tile_sel_t'(t));
    end

    rrf_tile u_tile (
      .clk         (clk),
      .rst         (rst),
      .lane0_index (lane_index[0]), .lane0_data (lane_data[0]), .lane0_wen (tile_wen[0]),
      .lane1_index (lane_index[1]), .lane1_data (lane_data[1]), .lane1_wen (tile_wen[1]),
      .lane2_index (lane_index[2]), .lane2_data (lane_data[2]), .lane2_wen (tile_wen[2]),
      .lane3_index (lane_index[3]), .lane3_data (lane_data[3]), .lane3_wen (tile_wen[3]),
      .lane4_index (lane_index[4]), .lane4_data (lane_data[4]), .lane4_wen (tile_wen[4]),
      .lane5_index (lane_index[5]), .lane5_data (lane_data[5]), .lane5_wen (tile_wen[5]),
      .read0_index (rd_index[0]),   .read0_data (tile_rd[t][0]),
      .read1_index (rd_index[1]),   .read1_data (tile_rd[t][1]),
      .read2_index (rd_index[2]),   .read2_data (tile_rd[t][2]),
      .read3_index (rd_index[3]),   .read3_data (tile_rd[t][3])
    );
  end

  rrf_read_stage u_read (
    .*,
    .read0_index      (rd_index[0]),
    .read1_index      (rd_index[1]),
    .read2_index      (rd_index[2]),
    .read3_index      (rd_index[3]),
    .tile0_read0_data (tile_rd[0][0]),
    .tile0_read1_data (tile_rd[0][1]),
    .tile0_read2_data (tile_rd[0][2]),
    .tile0_read3_data (tile_rd[0][3]),
    .tile1_read0_data (tile_rd[1][0]),
    .tile1_read1_data (tile_rd[1][1]),
    .tile1_read2_data (tile_rd[1][2]),
    .tile1_read3_data (tile_rd[1][3])
  );

endmodule

// File: verilog/rrf_read_stage.sv
/*
  Read stage.
  Registers read addresses and output enables under read_clk_en, hands the
  in-tile indices to the tiles and picks each port's value from the named tile.
*/
`timescale 1ns/1ns
`include "rrf_defs.svh"

module rrf_read_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                read_clk_en,
  input  rrf_pkg::rrf_addr_t  read0_addr,
  input  logic                read0_oe,
  input  rrf_pkg::rrf_addr_t  read1_addr,
  input  logic                read1_oe,
  input  rrf_pkg::rrf_addr_t  read2_addr,
  input  logic                read2_oe,
  input  rrf_pkg::rrf_addr_t  read3_addr,
  input  logic                read3_oe,
  output rrf_pkg::rrf_index_t read0_index,
  output rrf_pkg::rrf_index_t read1_index,
  output rrf_pkg::rrf_index_t read2_index,
  output rrf_pkg::rrf_index_t read3_index,
  input  rrf_pkg::rrf_data_t  tile0_read0_data,
  input  rrf_pkg::rrf_data_t  tile0_read1_data,
  input  rrf_pkg::rrf_data_t  tile0_read2_data,
  input  rrf_pkg::rrf_data_t  tile0_read3_data,
  input  rrf_pkg::rrf_data_t  tile1_read0_data,
  input  rrf_pkg::rrf_data_t  tile1_read1_data,
  input  rrf_pkg::rrf_data_t  tile1_read2_data,
  input  rrf_pkg::rrf_data_t  tile1_read3_data,
  output rrf_pkg::rrf_data_t  read0_data,
  output rrf_pkg::rrf_data_t  read1_data,
  output rrf_pkg::rrf_data_t  read2_data,
  output rrf_pkg::rrf_data_t  read3_data
);
  import rrf_pkg::*;

  localparam int IW = $bits(rrf_index_t);

  rrf_addr_t     addr_q [4];  // Captured read addresses.
  logic [3:0]    oe_q;        // Captured output enables, one per port.
  rrf_tile_sel_t tile_q [4];  // Tile field of each captured address.

  // Gives the value of one port, or zero when it is disabled or its tile is not populated.
  function automatic rrf_data_t pick(input logic oe, input rrf_tile_sel_t tile,
                                     input rrf_data_t t0, input rrf_data_t t1);
    if (!oe)
      return '0;
    if (tile == rrf_tile_sel_t'(0))
      return t0;
    if (tile == rrf_tile_sel_t'(1))
      return t1;
    return '0;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr_q <= '{default: '0};
      oe_q   <= '1;  // Enabled out of reset so every port shows register 0.
    end
    else if (read_clk_en)
    begin
      addr_q[0] <= read0_addr;
      addr_q[1] <= read1_addr;
      addr_q[2] <= read2_addr;
      addr_q[3] <= read3_addr;
      oe_q      <= {read3_oe, read2_oe, read1_oe, read0_oe};
    end
  end

  always_comb
  begin
    for (int p = 0; p < 4; p++)
      tile_q[p] = addr_q[p][`RRF_ADDR_WIDTH-1:IW];
  end

  assign read0_index = addr_q[0][IW-1:0];
  assign read1_index = addr_q[1][IW-1:0];
  assign read2_index = addr_q[2][IW-1:0];
  assign read3_index = addr_q[3][IW-1:0];

  assign read0_data = pick(oe_q[0], tile_q[0], tile0_read0_data, tile1_read0_data);
  assign read1_data = pick(oe_q[1], tile_q[1], tile0_read1_data, tile1_read1_data);
  assign read2_data = pick(oe_q[2], tile_q[2], tile0_read2_data, tile1_read2_data);
  assign read3_data = pick(oe_q[3], tile_q[3], tile0_read3_data, tile1_read3_data);

  // Addresses beyond the populated tiles would read as zero without notice.
  for (genvar p = 0; p < 4; p++)
  begin : g_chk
    a_tile_in_range: assert property (@(posedge clk) disable iff (rst)
      tile_q[p] < `RRF_TILES)
      else $error("rrf_read_stage: port %0d names an absent tile", p);
  end

endmodule

// File: verilog/rrf_tile.sv
/*
  Storage tile of sixteen register entries.
  Holds the cells and a four-port read multiplexer by in-tile index.
*/
`timescale 1ns/1ns
`include "rrf_defs.svh"

module rrf_tile (
  input  logic                clk,
  input  logic                rst,
  input  rrf_pkg::rrf_index_t lane0_index,
  input  rrf_pkg::rrf_data_t  lane0_data,
  input  logic                lane0_wen,
  input  rrf_pkg::rrf_index_t lane1_index,
  input  rrf_pkg::rrf_data_t  lane1_data,
  input  logic                lane1_wen,
  input  rrf_pkg::rrf_index_t lane2_index,
  input  rrf_pkg::rrf_data_t  lane2_data,
  input  logic                lane2_wen,
  input  rrf_pkg::rrf_index_t lane3_index,
  input  rrf_pkg::rrf_data_t  lane3_data,
  input  logic                lane3_wen,
  input  rrf_pkg::rrf_index_t lane4_index,
  input  rrf_pkg::rrf_data_t  lane4_data,
  input  logic                lane4_wen,
  input  rrf_pkg::rrf_index_t lane5_index,
  input  rrf_pkg::rrf_data_t  lane5_data,
  input  logic                lane5_wen,
  input  rrf_pkg::rrf_index_t read0_index,
  output rrf_pkg::rrf_data_t  read0_data,
  input  rrf_pkg::rrf_index_t read1_index,
  output rrf_pkg::rrf_data_t  read1_data,
  input  rrf_pkg::rrf_index_t read2_index,
  output rrf_pkg::rrf_data_t  read2_data,
  input  rrf_pkg::rrf_index_t read3_index,
  output rrf_pkg::rrf_data_t  read3_data
);
  import rrf_pkg::*;

  rrf_data_t cell_q [`RRF_TILE_ENTRIES];  // Current contents of every entry.

  for (genvar e = 0; e < `RRF_TILE_ENTRIES; e++)
  begin : g_cell
    rrf_cell #(
      .INDEX (e)
    ) u_cell (
      .clk         (clk),
      .rst         (rst),
      .lane0_index (lane0_index), .lane0_data (lane0_data), .lane0_wen (lane0_wen),
      .lane1_index (lane1_index), .lane1_data (lane1_data), .lane1_wen (lane1_wen),
      .lane2_index (lane2_index), .lane2_data (lane2_data), .lane2_wen (lane2_wen),
      .lane3_index (lane3_index), .lane3_data (lane3_data), .lane3_wen (lane3_wen),
      .lane4_index (lane4_index), .lane4_data (lane4_data), .lane4_wen (lane4_wen),
      .lane5_index (lane5_index), .lane5_data (lane5_data), .lane5_wen (lane5_wen),
      .q           (cell_q[e])
    );
  end

  // Reads are combinational from the entries.
  assign read0_data = cell_q[read0_index];
  assign read1_data = cell_q[read1_index];
  assign read2_data = cell_q[read2_index];
  assign read3_data = cell_q[read3_index];

endmodule

// File: verilog/rrf_cell.sv
/*
  One register entry of a storage tile.
  Decodes the six write lanes against its own index and keeps the lowest hitting lane.
*/
`timescale 1ns/1ns

module rrf_cell #(
  parameter int INDEX = 0
) (
  input  logic                clk,
  input  logic                rst,
  input  rrf_pkg::rrf_index_t lane0_index,
  input  rrf_pkg::rrf_data_t  lane0_data,
  input  logic                lane0_wen,
  input  rrf_pkg::rrf_index_t lane1_index,
  input  rrf_pkg::rrf_data_t  lane1_data,
  input  logic                lane1_wen,
  input  rrf_pkg::rrf_index_t lane2_index,
  input  rrf_pkg::rrf_data_t  lane2_data,
  input  logic                lane2_wen,
  input  rrf_pkg::rrf_index_t lane3_index,
  input  rrf_pkg::rrf_data_t  lane3_data,
  input  logic                lane3_wen,
  input  rrf_pkg::rrf_index_t lane4_index,
  input  rrf_pkg::rrf_data_t  lane4_data,
  input  logic                lane4_wen,
  input  rrf_pkg::rrf_index_t lane5_index,
  input  rrf_pkg::rrf_data_t  lane5_data,
  input  logic                lane5_wen,
  output rrf_pkg::rrf_data_t  q
);
  import rrf_pkg::*;

  localparam rrf_index_t MY_INDEX = rrf_index_t'(INDEX);

  logic [5:0] hit;      // Lanes writing this entry in this cycle.
  rrf_data_t  wr_data;  // Data of the winning lane.

  assign hit[0] = lane0_wen && (lane0_index == MY_INDEX);
  assign hit[1] = lane1_wen && (lane1_index == MY_INDEX);
  assign hit[2] = lane2_wen && (lane2_index == MY_INDEX);
  assign hit[3] = lane3_wen && (lane3_index == MY_INDEX);
  assign hit[4] = lane4_wen && (lane4_index == MY_INDEX);
  assign hit[5] = lane5_wen && (lane5_index == MY_INDEX);

  // Lowest lane number wins on a collision.
  assign wr_data = hit[0] ? lane0_data :
                   hit[1] ? lane1_data :
                   hit[2] ? lane2_data :
                   hit[3] ? lane3_data :
                   hit[4] ? lane4_data :
                   lane5_data;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      q <= '0;
    end
    else if (|hit)
    begin
      q <= wr_data;
    end
  end

endmodule

// File: verilog/rrf_write_merge.sv
/*
  Write merge stage.
  Folds the nine retirement write ports onto six internal write lanes,
  taking the ports in triples {0,3,6}, {1,4,7} and {2,5,8}.
*/
`timescale 1ns/1ns

module rrf_write_merge (
  input  logic               clk,
  input  rrf_pkg::rrf_addr_t write0_addr,
  input  rrf_pkg::rrf_data_t write0_data,
  input  logic               write0_wen,
  input  rrf_pkg::rrf_addr_t write1_addr,
  input  rrf_pkg::rrf_data_t write1_data,
  input  logic               write1_wen,
  input  rrf_pkg::rrf_addr_t write2_addr,
  input  rrf_pkg::rrf_data_t write2_data,
  input  logic               write2_wen,
  input  rrf_pkg::rrf_addr_t write3_addr,
  input  rrf_pkg::rrf_data_t write3_data,
  input  logic               write3_wen,
  input  rrf_pkg::rrf_addr_t write4_addr,
  input  rrf_pkg::rrf_data_t write4_data,
  input  logic               write4_wen,
  input  rrf_pkg::rrf_addr_t write5_addr,
  input  rrf_pkg::rrf_data_t write5_data,
  input  logic               write5_wen,
  input  rrf_pkg::rrf_addr_t write6_addr,
  input  rrf_pkg::rrf_data_t write6_data,
  input  logic               write6_wen,
  input  rrf_pkg::rrf_addr_t write7_addr,
  input  rrf_pkg::rrf_data_t write7_data,
  input  logic               write7_wen,
  input  rrf_pkg::rrf_addr_t write8_addr,
  input  rrf_pkg::rrf_data_t write8_data,
  input  logic               write8_wen,
  output rrf_pkg::rrf_addr_t lane0_addr,
  output rrf_pkg::rrf_data_t lane0_data,
  output logic               lane0_wen,
  output rrf_pkg::rrf_addr_t lane1_addr,
  output rrf_pkg::rrf_data_t lane1_data,
  output logic               lane1_wen,
  output rrf_pkg::rrf_addr_t lane2_addr,
  output rrf_pkg::rrf_data_t lane2_data,
  output logic               lane2_wen,
  output rrf_pkg::rrf_addr_t lane3_addr,
  output rrf_pkg::rrf_data_t lane3_data,
  output logic               lane3_wen,
  output rrf_pkg::rrf_addr_t lane4_addr,
  output rrf_pkg::rrf_data_t lane4_data,
  output logic               lane4_wen,
  output rrf_pkg::rrf_addr_t lane5_addr,
  output rrf_pkg::rrf_data_t lane5_data,
  output logic               lane5_wen
);

  logic [2:0] take_hi;  // Upper lane of a triple carries the third port.

  assign take_hi = {write2_wen & write8_wen, write1_wen & write7_wen, write0_wen & write6_wen};

  // Lower lanes prefer the first port of the triple, then fall back to the second.
  assign lane0_addr = write0_wen ? write0_addr : write3_addr;
  assign lane0_data = write0_wen ? write0_data : write3_data;
  assign lane0_wen  = write0_wen | write3_wen;
  assign lane1_addr = write1_wen ? write1_addr : write4_addr;
  assign lane1_data = write1_wen ? write1_data : write4_data;
  assign lane1_wen  = write1_wen | write4_wen;
  assign lane2_addr = write2_wen ? write2_addr : write5_addr;
  assign lane2_data = write2_wen ? write2_data : write5_data;
  assign lane2_wen  = write2_wen | write5_wen;

  // Upper lanes carry the second port unless the first and third are both busy.
  assign lane3_addr = take_hi[0] ? write6_addr : write3_addr;
  assign lane3_data = take_hi[0] ? write6_data : write3_data;
  assign lane3_wen  = take_hi[0] | write3_wen;
  assign lane4_addr = take_hi[1] ? write7_addr : write4_addr;
  assign lane4_data = take_hi[1] ? write7_data : write4_data;
  assign lane4_wen  = take_hi[1] | write4_wen;
  assign lane5_addr = take_hi[2] ? write8_addr : write5_addr;
  assign lane5_data = take_hi[2] ? write8_data : write5_data;
  assign lane5_wen  = take_hi[2] | write5_wen;

  // A full triple would need three lanes and one write would be lost.
  a_no_full_triple: assert property (@(posedge clk)
    !(write0_wen && write3_wen && write6_wen) &&
    !(write1_wen && write4_wen && write7_wen) &&
    !(write2_wen && write5_wen && write8_wen))
    else $error("rrf_write_merge: all three ports of a triple enabled");

endmodule

// File: verilog/rrf_pkg.sv
/*
  Shared vector types of the register file.
  Covers register data, full addresses, in-tile indices and tile selects.
*/
`include "rrf_defs.svh"

package rrf_pkg;

  typedef logic [`RRF_DATA_WIDTH-1:0] rrf_data_t;     // One register value.
  typedef logic [`RRF_ADDR_WIDTH-1:0] rrf_addr_t;     // Tile field above the index.

  // Entry index inside one tile.
  typedef logic [$clog2(`RRF_TILE_ENTRIES)-1:0] rrf_index_t;

  // Tile number field in the upper bits of an address.
  typedef logic [`RRF_ADDR_WIDTH-$clog2(`RRF_TILE_ENTRIES)-1:0] rrf_tile_sel_t;

endpackage

// File: include/rrf_defs.svh
/*
  Sizing defines for the floating-point retirement register file.
  Covers the data width, the address width, the entries per tile and the tile count.
*/
`ifndef RRF_DEFS_SVH
`define RRF_DEFS_SVH

// One register holds a double-precision value.
`define RRF_DATA_WIDTH   64
// Tile field plus in-tile index.
`define RRF_ADDR_WIDTH   6
// Entries per storage tile.
`define RRF_TILE_ENTRIES 16
// Populated tiles that together hold the 32 registers.
`define RRF_TILES        2

`endif
